/* dv/clockGen.sv */
`default_nettype none

// Free-running 50 MHz clock and a synchronous reset pulse
module clockGen (
	output logic CLK50MHZ,
	output logic rstN
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		CLK50MHZ = 1'b0;
		forever #10 CLK50MHZ = ~CLK50MHZ;
	end

	// Reset held low for three rising edges
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge CLK50MHZ);
		#1;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

/* dv/uartTb.sv */
`default_nettype none

// Testbench for the serial link with loopback, busy masking, framing error and false start
module uartTb
	import uartPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int bitCycles = clkFreqHz / baudRate;
	localparam int halfBit = bitCycles / 2;
	localparam int frameCycles = 10 * bitCycles;
	localparam int timeoutCycles = 20 * bitCycles;

	logic CLK50MHZ;
	logic rstN;
	logic txStart;
	uartByte_t txData;
	logic txd;
	logic txBusy;
	logic rxd;
	logic rxValid;
	rxFrame_t rxFrame;

	// Line mux between the transmitter and the serial driver
	logic loopback;
	logic drvLine;
	logic startSeen;
	int errCount;
	int seed;
	rxFrame_t rxQueue[$];
	uartByte_t expQueue[$];

	assign rxd = loopback ? txd : drvLine;

	clockGen clkSrc (
		.CLK50MHZ(CLK50MHZ),
		.rstN(rstN)
	);

	uartTop i_dut (
		.CLK50MHZ(CLK50MHZ),
		.rstN(rstN),
		.txStart(txStart),
		.txData(txData),
		.txd(txd),
		.txBusy(txBusy),
		.rxd(rxd),
		.rxValid(rxValid),
		.rxFrame(rxFrame)
	);

	// Quiet outputs until the first strobe
	assert property (@(posedge CLK50MHZ) disable iff (!rstN)
		!startSeen |-> (txd && !txBusy && !rxValid))
	else begin
		errCount++;
		$display("** Error: txd = 0x%0h, txBusy = 0x%0h, rxValid = 0x%0h, expected 0x1, 0x0, 0x0",
			txd, txBusy, rxValid);
	end

	// Accepted strobe raises busy and the start bit together
	assert property (@(posedge CLK50MHZ) disable iff (!rstN)
		(txStart && !txBusy) |=> (txBusy && !txd))
	else begin
		errCount++;
		$display("** Error: txBusy = 0x%0h, txd = 0x%0h after txStart, expected 0x1, 0x0",
			txBusy, txd);
	end

	assert property (@(posedge CLK50MHZ) disable iff (!rstN) rxValid |=> !rxValid)
	else begin
		errCount++;
		$display("** Error: rxValid = 0x1 for two cycles, expected 0x0 in the second");
	end

	// Serial monitor of the receiver output
	always @(negedge CLK50MHZ) begin
		if (rstN && rxValid) begin
			rxQueue.push_back(rxFrame);
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			errCount++;
			$display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic abortRun(input string what);
		$display("timeout waiting for %s", what);
		$display("Closing report: %0d errors plus a timeout", errCount);
		$display("Testbench failed");
		$finish;
	endtask

	task automatic waitTxIdle();
		int cnt;
		cnt = 0;
		while (txBusy && cnt < timeoutCycles) begin
			@(negedge CLK50MHZ);
			cnt++;
		end
		if (txBusy) begin
			abortRun("txBusy to fall");
		end
	endtask

	// The queue only grows on falling edges, so it is read on rising ones
	task automatic waitRxFrames(input int count);
		int cnt;
		cnt = 0;
		while (rxQueue.size() < count && cnt < timeoutCycles) begin
			@(posedge CLK50MHZ);
			cnt++;
		end
		if (rxQueue.size() < count) begin
			abortRun("rxValid");
		end
	endtask

	// Strobe one byte and check the line at the middle of every bit
	task automatic sendFrame(input uartByte_t value, input bit pokeBusy);
		logic [9:0] bits;
		int cnt;
		int k;
		bits = {1'b1, value, 1'b0};
		@(posedge CLK50MHZ);
		#1;
		txStart = 1'b1;
		txData = value;
		startSeen = 1'b1;
		@(posedge CLK50MHZ);
		#1;
		txStart = 1'b0;
		txData = ~value;
		expQueue.push_back(value);
		cnt = 0;
		while (txd !== 1'b0 && cnt < timeoutCycles) begin
			@(negedge CLK50MHZ);
			cnt++;
		end
		if (txd !== 1'b0) begin
			abortRun("txd start bit");
		end
		for (k = 0; k < 10; k++) begin
			repeat ((k == 0) ? halfBit : bitCycles) @(negedge CLK50MHZ);
			checkValue("txd", txd, bits[k]);
			// A second strobe in the middle of the data bits must be ignored
			if (pokeBusy && k == 3) begin
				checkValue("txBusy", txBusy, 1);
				@(posedge CLK50MHZ);
				#1;
				txStart = 1'b1;
				txData = value ^ 8'h5a;
				@(posedge CLK50MHZ);
				#1;
				txStart = 1'b0;
			end
		end
	endtask

	// Drives a frame on rxd from the testbench side
	task automatic driveSerial(input uartByte_t value, input logic stopBit);
		logic [9:0] bits;
		int k;
		bits = {stopBit, value, 1'b0};
		for (k = 0; k < 10; k++) begin
			@(posedge CLK50MHZ);
			#1;
			drvLine = bits[k];
			repeat (bitCycles - 1) @(posedge CLK50MHZ);
		end
		@(posedge CLK50MHZ);
		#1;
		drvLine = 1'b1;
	endtask

	task automatic checkReceived(input uartByte_t expData, input logic expErr);
		rxFrame_t got;
		if (rxQueue.size() == 0) begin
			errCount++;
			$display("No received frame to compare with byte 0x%0h", expData);
		end else begin
			got = rxQueue.pop_front();
			checkValue("rxFrame.data", got.data, expData);
			checkValue("rxFrame.frameError", got.frameError, expErr);
		end
	endtask

	initial begin
		uartByte_t value;
		int cnt;
		int i;
		errCount = 0;
		seed = 32'hc6543eea;
		txStart = 1'b0;
		txData = '0;
		loopback = 1'b1;
		drvLine = 1'b1;
		startSeen = 1'b0;

		cnt = 0;
		while (!rstN && cnt < 20) begin
			@(negedge CLK50MHZ);
			cnt++;
		end
		if (!rstN) begin
			abortRun("reset release");
		end
		repeat (100) @(negedge CLK50MHZ);

		// Loopback, back to back, with two masked strobes
		for (i = 0; i < 16; i++) begin
			value = uartByte_t'($random(seed));
			sendFrame(value, (i == 4) || (i == 11));
			waitTxIdle();
		end
		waitRxFrames(expQueue.size());
		repeat (frameCycles) @(posedge CLK50MHZ);
		checkValue("rxValid pulses", rxQueue.size(), expQueue.size());
		while (expQueue.size() > 0) begin
			checkReceived(expQueue.pop_front(), 1'b0);
		end
		rxQueue.delete();

		// Low stop bit from the driver
		@(posedge CLK50MHZ);
		#1;
		loopback = 1'b0;
		value = uartByte_t'($random(seed));
		driveSerial(value, 1'b0);
		waitRxFrames(1);
		checkReceived(value, 1'b1);
		// The low stop bit may look like a new start, so let it settle
		repeat (2 * frameCycles) @(posedge CLK50MHZ);
		rxQueue.delete();

		// Glitch of an eighth of a bit
		@(posedge CLK50MHZ);
		#1;
		drvLine = 1'b0;
		repeat (bitCycles / 8) @(posedge CLK50MHZ);
		#1;
		drvLine = 1'b1;
		repeat (2 * frameCycles) @(posedge CLK50MHZ);
		checkValue("rxValid pulses", rxQueue.size(), 0);
		value = uartByte_t'($random(seed));
		driveSerial(value, 1'b1);
		waitRxFrames(1);
		checkReceived(value, 1'b0);

		$display("Closing report: %0d errors", errCount);
		if (errCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the serial link testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module uartTb -o uartSim \
	&& ./obj_dir/uartSim > sim.log 2>&1 \
	|| { echo "Build or simulation error"; exit 1; }

grep -qx "Testbench passed" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

/* sources.f */
verilog/uartPkg.sv
verilog/baudTickGen.sv
verilog/uartTx.sv
verilog/uartRx.sv
verilog/uartTop.sv
dv/clockGen.sv
dv/uartTb.sv

/* verilog/baudTickGen.sv */
`default_nettype none

// Fractional rate generator
// The carry out of the accumulator gives one single-cycle tick; the
// remainder stays in the low bits so the mean rate is exact
module baudTickGen
	import uartPkg::*;
#(
	parameter baudAcc_t increment = txBaudInc
) (
	input logic CLK50MHZ,
	input logic rstN,
	input logic enable,
	output logic tick
);

	baudAcc_t acc;
	baudAcc_t accNext;

	// Drop the previous carry before adding
	assign accNext = {1'b0, acc[baudAccWidth-1:0]} + increment;

	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			acc <= '0;
		end else if (!enable) begin
			// Idle keeps the phase at zero so every run starts fresh
			acc <= '0;
		end else begin
			acc <= accNext;
		end
	end

	// A carry left over from the last enabled cycle is not a tick
	assign tick = enable & acc[baudAccWidth];

endmodule

`default_nettype wire

/* verilog/uartPkg.sv */
`default_nettype none

package uartPkg;

	// System clock and serial line rate
	localparam int clkFreqHz = 50000000;
	localparam int baudRate = 115200;

	// Fractional baud accumulator, the top bit is the carry
	localparam int baudAccWidth = 17;

	// Receiver ticks per bit
	localparam int oversample = 16;

	typedef logic [baudAccWidth:0] baudAcc_t;

	// Increment for one tick per bit, rounded to nearest
	localparam baudAcc_t txBaudInc = baudAcc_t'(
		((baudRate << (baudAccWidth - 4)) + (clkFreqHz >> 5)) / (clkFreqHz >> 4)
	);

	// Same scaling at the oversampled rate, wider math to avoid overflow
	localparam baudAcc_t rxBaudInc = baudAcc_t'(
		((longint'(baudRate * oversample) << (baudAccWidth - 4)) + (clkFreqHz >> 5))
			/ (clkFreqHz >> 4)
	);

	// One character on the line
	typedef logic [7:0] uartByte_t;

	// Index of a data bit within a character
	typedef logic [2:0] bitIdx_t;

	// Position within one bit, counted in oversample ticks
	typedef logic [$clog2(oversample)-1:0] ovsCount_t;

	typedef enum logic [1:0] {
		txIdleSt,
		txStartSt,
		txDataSt,
		txStopSt
	} txState_e;

	typedef enum logic [1:0] {
		rxIdleSt,
		rxStartSt,
		rxDataSt,
		rxStopSt
	} rxState_e;

	// Result of one received frame
	typedef struct packed {
		uartByte_t data;
		logic frameError;
	} rxFrame_t;

endpackage

`default_nettype wire

/* verilog/uartRx.sv */
`default_nettype none

// Serial receiver, 8N1, LSB first, 16x oversampled
// Samples each bit in its middle and checks the stop bit
module uartRx
	import uartPkg::*;
(
	input logic CLK50MHZ,
	input logic rstN,
	input logic rxd,
	input logic sampleTick,
	output logic tickEnable,
	output logic valid,
	output rxFrame_t frame
);

	logic rxdMeta;
	logic rxdSync;
	rxState_e state;
	ovsCount_t ovsCnt;
	bitIdx_t bitCnt;
	uartByte_t shiftReg;
	logic midStart;
	logic midBit;
	logic lastBit;

	// Two-flop synchronizer, idle line is high
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			rxdMeta <= 1'b1;
			rxdSync <= 1'b1;
		end else begin
			rxdMeta <= rxd;
			rxdSync <= rxdMeta;
		end
	end

	// Ticks run while hunting a start edge or inside a frame
	assign tickEnable = (state != rxIdleSt) || !rxdSync;

	// Middle of the start bit after 8 ticks, then every 16 ticks
	assign midStart = sampleTick && (ovsCnt == ovsCount_t'(oversample / 2 - 1));
	assign midBit = sampleTick && (ovsCnt == ovsCount_t'(oversample - 1));

	assign lastBit = (bitCnt == bitIdx_t'(7));

	// Frame sequencer
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			state <= rxIdleSt;
		end else begin
			case (state)
				rxIdleSt: begin
					if (!rxdSync) begin
						state <= rxStartSt;
					end
				end
				rxStartSt: begin
					// A glitch is high again by mid-bit
					if (midStart) begin
						state <= rxdSync ? rxIdleSt : rxDataSt;
					end
				end
				rxDataSt: begin
					if (midBit && lastBit) begin
						state <= rxStopSt;
					end
				end
				rxStopSt: begin
					if (midBit) begin
						state <= rxIdleSt;
					end
				end
				default: begin
					state <= rxIdleSt;
				end
			endcase
		end
	end

	// Oversample and bit counters
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			ovsCnt <= '0;
			bitCnt <= '0;
		end else if (state == rxIdleSt) begin
			ovsCnt <= '0;
			bitCnt <= '0;
		end else if (state == rxStartSt && midStart) begin
			// Realign on the middle of the start bit
			ovsCnt <= '0;
		end else if (sampleTick) begin
			ovsCnt <= ovsCnt + 1'b1;
			if (state == rxDataSt && midBit) begin
				bitCnt <= bitCnt + 1'b1;
			end
		end
	end

	// Data shifts in from the top, so bit 0 ends up in the LSB
	always_ff @(posedge CLK50MHZ) begin
		if (state == rxDataSt && midBit) begin
			shiftReg <= {rxdSync, shiftReg[7:1]};
		end
	end

	// Result and valid pulse, a cycle after the stop sample
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			valid <= 1'b0;
			frame <= '0;
		end else begin
			valid <= 1'b0;
			if (state == rxStopSt && midBit) begin
				valid <= 1'b1;
				frame.data <= shiftReg;
				frame.frameError <= !rxdSync;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/uartTop.sv */
`default_nettype none

// Serial link subsystem
// Transmitter and receiver side by side, each with its own rate generator
module uartTop
	import uartPkg::*;
(
	input logic CLK50MHZ,
	input logic rstN,
	input logic txStart,
	input uartByte_t txData,
	output logic txd,
	output logic txBusy,
	input logic rxd,
	output logic rxValid,
	output rxFrame_t rxFrame
);

	logic txBaudTick;
	logic rxSampleTick;
	logic rxTickEnable;

	// One tick per bit, runs only while a frame is sent
	baudTickGen #(
		.increment(txBaudInc)
	) txTick (
		.CLK50MHZ(CLK50MHZ),
		.rstN(rstN),
		.enable(txBusy),
		.tick(txBaudTick)
	);

	uartTx tx (
		.CLK50MHZ(CLK50MHZ),
		.rstN(rstN),
		.start(txStart),
		.data(txData),
		.baudTick(txBaudTick),
		.txd(txd),
		.busy(txBusy)
	);

	// Sixteen ticks per bit for the receiver
	baudTickGen #(
		.increment(rxBaudInc)
	) rxTick (
		.CLK50MHZ(CLK50MHZ),
		.rstN(rstN),
		.enable(rxTickEnable),
		.tick(rxSampleTick)
	);

	uartRx rx (
		.CLK50MHZ(CLK50MHZ),
		.rstN(rstN),
		.rxd(rxd),
		.sampleTick(rxSampleTick),
		.tickEnable(rxTickEnable),
		.valid(rxValid),
		.frame(rxFrame)
	);

endmodule

`default_nettype wire

/* verilog/uartTx.sv */
`default_nettype none

// Serial transmitter, 8N1, LSB first
// The byte is taken at the start strobe; the line stays registered
module uartTx
	import uartPkg::*;
(
	input logic CLK50MHZ,
	input logic rstN,
	input logic start,
	input uartByte_t data,
	input logic baudTick,
	output logic txd,
	output logic busy
);

	txState_e state;
	uartByte_t shiftReg;
	bitIdx_t bitCnt;
	logic accept;
	logic lastBit;

	// Strobes while a frame is in flight are dropped
	assign accept = start && (state == txIdleSt);

	assign lastBit = (bitCnt == bitIdx_t'(7));

	// Busy also enables the tick generator
	assign busy = (state != txIdleSt);

	// Frame sequencer
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			state <= txIdleSt;
		end else begin
			case (state)
				txIdleSt: begin
					if (accept) begin
						state <= txStartSt;
					end
				end
				txStartSt: begin
					if (baudTick) begin
						state <= txDataSt;
					end
				end
				txDataSt: begin
					if (baudTick && lastBit) begin
						state <= txStopSt;
					end
				end
				txStopSt: begin
					// Full stop bit before the next frame
					if (baudTick) begin
						state <= txIdleSt;
					end
				end
				default: begin
					state <= txIdleSt;
				end
			endcase
		end
	end

	// Data bit counter
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			bitCnt <= '0;
		end else if (baudTick) begin
			if (state == txStartSt) begin
				bitCnt <= '0;
			end else if (state == txDataSt) begin
				bitCnt <= bitCnt + 1'b1;
			end
		end
	end

	// Shift register
	always_ff @(posedge CLK50MHZ) begin
		if (accept) begin
			shiftReg <= data;
		end else if (baudTick && (state == txStartSt || state == txDataSt)) begin
			shiftReg <= {1'b0, shiftReg[7:1]};
		end
	end

	// Line driver, changes only on a clock edge
	always_ff @(posedge CLK50MHZ) begin
		if (!rstN) begin
			txd <= 1'b1;
		end else begin
			case (state)
				txIdleSt: begin
					// Start bit goes out together with busy
					if (accept) begin
						txd <= 1'b0;
					end
				end
				txStartSt: begin
					if (baudTick) begin
						txd <= shiftReg[0];
					end
				end
				txDataSt: begin
					if (baudTick) begin
						txd <= lastBit ? 1'b1 : shiftReg[0];
					end
				end
				default: begin
					txd <= 1'b1;
				end
			endcase
		end
	end

endmodule

`default_nettype wire
